// File: rdma_resp_gen.f
hw/roce_hdr_pkg.sv
hw/resp_gen_cfg_pkg.sv
hw/qp_cfg_regs.sv
hw/rd_req_capture.sv
hw/resp_hdr_build.sv
hw/axis_beat_serializer.sv
hw/rdma_resp_gen.sv
verif/tb_clk_gen.sv
verif/rdma_resp_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status follows the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module rdma_resp_gen_tb \
  -f rdma_resp_gen.f \
  --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vrdma_resp_gen_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/rdma_resp_gen_tb.sv
`timescale 1ns/10ps
module rdma_resp_gen_tb;

  logic                                core_clk;
  logic                                core_aresetn;
  logic                                psel_i;
  logic                                penable_i;
  logic                                pwrite_i;
  logic [7:0]                          paddr_i;
  logic [31:0]                         pwdata_i;
  logic [31:0]                         prdata_o;
  logic                                pready_o;
  logic                                pslverr_o;
  logic                                req_valid_i;
  logic                                req_ready_o;
  logic [resp_gen_cfg_pkg::DATA_W-1:0] req_data_i;
  logic [resp_gen_cfg_pkg::DATA_W-1:0] m_axis_tdata_o;
  logic [resp_gen_cfg_pkg::KEEP_W-1:0] m_axis_tkeep_o;
  logic                                m_axis_tvalid_o;
  logic                                m_axis_tlast_o;
  logic                                m_axis_tready_i;

  logic [31:0]                         reg_val [0:15];  // last written value per register
  logic [resp_gen_cfg_pkg::DATA_W-1:0] exp_data [$];
  logic [resp_gen_cfg_pkg::KEEP_W-1:0] exp_keep [$];
  logic                                exp_last [$];
  int                                  errors = 0;
  int                                  bad_tests = 0;
  int                                  err_mark = 0;
  bit                                  rand_ready = 1'b0;

  tb_clk_gen u_clk (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn)
  );

  rdma_resp_gen dut0 (
    .core_clk        (core_clk),
    .core_aresetn    (core_aresetn),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_data_i      (req_data_i),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tready_i (m_axis_tready_i)
  );

  task automatic note_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic give_up(input string why);
    $display("%0t ns: %s", $time, why);
    $display("tests failed");
    $finish;
  endtask

  task automatic close_test(input string name);
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: FAIL, %0d errors", name, errors - err_mark);
      bad_tests++;
    end
    err_mark = errors;
  endtask

  // register index k covers source and ctrl first, then lo/hi/ip per qp
  function automatic logic [7:0] reg_addr(input int k);
    if (k < 4) return 8'(k * 4);
    return 8'(resp_gen_cfg_pkg::REG_QP_BASE + ((k - 4) / 3) * resp_gen_cfg_pkg::REG_QP_STRIDE
              + ((k - 4) % 3) * 4);
  endfunction

  function automatic logic [31:0] reg_mask(input int k);
    if (k == 3) return 32'h0000_0001;
    if (k == 1 || (k >= 4 && (k - 4) % 3 == 1)) return 32'h0000_ffff;  // mac hi
    return 32'hffff_ffff;
  endfunction

  function automatic logic [511:0] keep_mask(input logic [63:0] keep);
    logic [511:0] m;
    for (int i = 0; i < 64; i++) begin
      m[i*8 +: 8] = {8{keep[i]}};
    end
    return m;
  endfunction

  function automatic logic [511:0] make_req(input logic [7:0] opc, input logic [23:0] qp,
                                            input logic [23:0] psn);
    logic [511:0] d;
    for (int i = 0; i < 16; i++) begin
      d[i*32 +: 32] = $urandom;  // random filler
    end
    d[42*8 +: 8] = opc;
    d[47*8 +: 8] = qp[23:16];
    d[48*8 +: 8] = qp[15:8];
    d[49*8 +: 8] = qp[7:0];
    d[51*8 +: 8] = psn[23:16];
    d[52*8 +: 8] = psn[15:8];
    d[53*8 +: 8] = psn[7:0];
    return d;
  endfunction

  // reference packet split into expected beats
  function automatic void push_expected(input logic is_ack, input logic [23:0] qp,
                                        input logic [23:0] psn);
    logic [47:0]  smac;
    logic [47:0]  dmac;
    logic [31:0]  sip;
    logic [31:0]  dip;
    logic [15:0]  ip_len;
    logic [159:0] ip;
    logic [31:0]  sum;
    logic [15:0]  csum;
    logic [463:0] h;
    logic [511:0] d;
    logic [63:0]  kp;
    int           idx;
    int           len;
    int           nbeats;
    int           p;
    idx    = int'(qp[1:0]);
    smac   = {reg_val[1][15:0], reg_val[0]};
    sip    = reg_val[2];
    dmac   = {reg_val[5 + 3*idx][15:0], reg_val[4 + 3*idx]};
    dip    = reg_val[6 + 3*idx];
    ip_len = 16'(44 + (is_ack ? 0 : roce_hdr_pkg::RD_RESP_PAYLOAD_BYTES));
    ip = {roce_hdr_pkg::IP_VER_IHL, roce_hdr_pkg::IP_TOS, ip_len, roce_hdr_pkg::IP_ID,
          roce_hdr_pkg::IP_FLAGS, roce_hdr_pkg::IP_TTL, roce_hdr_pkg::IP_PROTO_UDP,
          16'h0000, sip, dip};
    sum = 0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 32'(ip[i*16 +: 16]);
    end
    while (sum > 32'h0000_ffff) begin
      sum = (sum & 32'h0000_ffff) + (sum >> 16);  // end-around carry
    end
    csum = ~sum[15:0];
    h = {dmac, smac, roce_hdr_pkg::ETH_TYPE_IPV4, roce_hdr_pkg::IP_VER_IHL,
         roce_hdr_pkg::IP_TOS, ip_len, roce_hdr_pkg::IP_ID, roce_hdr_pkg::IP_FLAGS,
         roce_hdr_pkg::IP_TTL, roce_hdr_pkg::IP_PROTO_UDP, csum, sip, dip,
         roce_hdr_pkg::UDP_SRC_PORT, roce_hdr_pkg::UDP_DST_PORT, 16'(ip_len - 16'd20),
         16'h0000, is_ack ? roce_hdr_pkg::OPC_ACK : roce_hdr_pkg::OPC_RD_RESP_ONLY, 8'h00,
         roce_hdr_pkg::BTH_PKEY, 8'h00, qp, 8'h00, psn, 32'h0};
    len    = is_ack ? 58 : 58 + roce_hdr_pkg::RD_RESP_PAYLOAD_BYTES;
    nbeats = (len + 63) / 64;
    for (int b = 0; b < nbeats; b++) begin
      d  = '0;
      kp = '0;
      for (int i = 0; i < 64; i++) begin
        p = b * 64 + i;
        if (p < len) begin
          d[i*8 +: 8] = (p < 58) ? h[463 - 8*p -: 8] : psn[7:0];
          kp[i] = 1'b1;
        end
      end
      exp_data.push_back(d);
      exp_keep.push_back(kp);
      exp_last.push_back(b == nbeats - 1);
    end
  endfunction

  // all tasks below start and end 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge core_clk);
    #1;
    penable_i = 1'b1;
    n = 0;
    @(posedge core_clk);
    while (!pready_o) begin
      n++;
      if (n > 16) give_up("APB access never completed");
      @(posedge core_clk);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input int k, input logic [31:0] v);
    logic [31:0] rd;
    logic        err;
    reg_val[k] = v;
    apb_access(1'b1, reg_addr(k), v, rd, err);
    assert (!err) else note_mismatch($sformatf("pslverr on write to %h", reg_addr(k)));
  endtask

  task automatic read_check(input int k);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, reg_addr(k), 32'h0, rd, err);
    assert (!err) else note_mismatch($sformatf("pslverr on read of %h", reg_addr(k)));
    assert (rd == (reg_val[k] & reg_mask(k)))
      else note_mismatch($sformatf("reg %h read %h, expected %h", reg_addr(k), rd,
                                   reg_val[k] & reg_mask(k)));
  endtask

  task automatic send_req(input logic [511:0] data);
    int n;
    req_valid_i = 1'b1;
    req_data_i  = data;
    n = 0;
    @(posedge core_clk);
    while (!req_ready_o) begin
      n++;
      if (n > 500) give_up("request was never accepted");
      @(posedge core_clk);
    end
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic issue_req(input logic [7:0] opc, input logic [23:0] qp, input logic [23:0] psn);
    if (opc == roce_hdr_pkg::OPC_RD_REQ || opc == roce_hdr_pkg::OPC_WR_ONLY) begin
      push_expected(opc == roce_hdr_pkg::OPC_WR_ONLY, qp, psn);
    end
    send_req(make_req(opc, qp, psn));
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (exp_data.size() != 0) begin
      @(posedge core_clk);
      #1;
      n++;
      if (n > 1000) give_up($sformatf("timed out waiting for %s output", what));
    end
  endtask

  initial begin
    m_axis_tready_i = 1'b1;
    forever begin
      @(posedge core_clk);
      #1;
      m_axis_tready_i = rand_ready ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  // stream output against the model
  always @(posedge core_clk) begin
    logic [511:0] mask;
    if (core_aresetn && m_axis_tvalid_o && m_axis_tready_i) begin
      if (exp_data.size() == 0) begin
        note_mismatch("output beat while no packet was expected");
      end else begin
        mask = keep_mask(exp_keep[0]);
        assert (m_axis_tkeep_o == exp_keep[0])
          else note_mismatch($sformatf("tkeep %h, expected %h", m_axis_tkeep_o, exp_keep[0]));
        assert (m_axis_tlast_o == exp_last[0])
          else note_mismatch($sformatf("tlast %b, expected %b", m_axis_tlast_o, exp_last[0]));
        assert ((m_axis_tdata_o & mask) == (exp_data[0] & mask))
          else note_mismatch("tdata differs from the reference packet");
        void'(exp_data.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
      end
    end
  end

  hold_under_stall: assert property (@(posedge core_clk) disable iff (!core_aresetn)
      m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o && $stable(m_axis_tdata_o)
      && $stable(m_axis_tkeep_o) && $stable(m_axis_tlast_o))
    else note_mismatch("beat changed or dropped while stalled");

  apb_no_wait: assert property (@(posedge core_clk) disable iff (!core_aresetn)
      psel_i && penable_i |-> pready_o)
    else note_mismatch("pready low in an APB access phase");

  initial begin
    logic [7:0]  bad_addr [0:3];
    logic [31:0] rd;
    logic        err;
    logic [7:0]  opc;
    int unsigned sel;
    int          n;
    void'($urandom(73351));
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    req_valid_i = 1'b0;
    req_data_i  = '0;
    for (int k = 0; k < 16; k++) begin
      reg_val[k] = '0;
    end
    bad_addr = '{8'h03, 8'h1c, 8'h50, 8'hfc};

    n = 0;
    while (core_aresetn !== 1'b1) begin
      @(posedge core_clk);
      n++;
      if (n > 20) give_up("reset was never released");
    end
    @(posedge core_clk);
    #1;

    // test 1 reset state and no acceptance until enabled
    assert (!m_axis_tvalid_o && !m_axis_tlast_o && !req_ready_o && !pslverr_o)
      else note_mismatch("outputs not low after reset");
    req_valid_i = 1'b1;
    req_data_i  = make_req(roce_hdr_pkg::OPC_RD_REQ, 24'h1, 24'h5);
    repeat (6) begin
      @(posedge core_clk);
      assert (!req_ready_o) else note_mismatch("req_ready high before enable");
    end
    #1;
    req_valid_i = 1'b0;
    for (int k = 0; k < 16; k++) begin
      read_check(k);  // all zero out of reset
    end
    write_reg(3, 32'h1);
    assert (req_ready_o) else note_mismatch("req_ready low after enable");
    close_test("test 1 reset and enable");

    // test 2 register map
    for (int k = 0; k < 16; k++) begin
      write_reg(k, (k == 3) ? ($urandom | 32'h1) : $urandom);
    end
    for (int k = 0; k < 16; k++) begin
      read_check(k);
    end
    for (int i = 0; i < 4; i++) begin
      apb_access(1'b1, bad_addr[i], $urandom, rd, err);
      assert (err) else note_mismatch($sformatf("no pslverr on write to %h", bad_addr[i]));
      apb_access(1'b0, bad_addr[i], 32'h0, rd, err);
      assert (err) else note_mismatch($sformatf("no pslverr on read of %h", bad_addr[i]));
      assert (rd == 32'h0) else note_mismatch($sformatf("unmapped read returned %h", rd));
    end
    for (int k = 0; k < 16; k++) begin
      read_check(k);  // unmapped writes left no trace
    end
    close_test("test 2 register access");

    // test 3 one read response per qp
    for (int q = 0; q < 4; q++) begin
      issue_req(roce_hdr_pkg::OPC_RD_REQ, {22'($urandom), 2'(q)}, 24'($urandom));
      drain("read response");
    end
    close_test("test 3 read responses");

    // test 4 ack then an opcode that is dropped
    issue_req(roce_hdr_pkg::OPC_WR_ONLY, {22'($urandom), 2'd2}, 24'($urandom));
    drain("ack");
    issue_req(8'h04, 24'($urandom), 24'($urandom));
    repeat (12) @(posedge core_clk);
    #1;
    close_test("test 4 ack and dropped opcode");

    // test 5 mixed burst under random back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < 12; i++) begin
      sel = $urandom % 5;
      opc = (sel < 2) ? roce_hdr_pkg::OPC_RD_REQ
          : (sel < 4) ? roce_hdr_pkg::OPC_WR_ONLY : 8'h04;
      issue_req(opc, 24'($urandom), 24'($urandom));
    end
    drain("burst");
    rand_ready = 1'b0;
    repeat (4) @(posedge core_clk);
    #1;
    close_test("test 5 back-pressure burst");

    $display("tests run: 5, tests with errors: %0d, failed checks: %0d", bad_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/10ps
module tb_clk_gen (
  output logic core_clk,
  output logic core_aresetn
);

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;  // 100 ns period
  end

  initial begin
    core_aresetn = 1'b0;
    repeat (8) @(posedge core_clk);
    #1;
    core_aresetn = 1'b1;
  end

endmodule

// File: hw/rdma_resp_gen.sv
`timescale 1ns/10ps
module rdma_resp_gen (
  input  logic                                core_clk,
  input  logic                                core_aresetn,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [7:0]                          paddr_i,
  input  logic [31:0]                         pwdata_i,
  output logic [31:0]                         prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [resp_gen_cfg_pkg::DATA_W-1:0] req_data_i,
  output logic [resp_gen_cfg_pkg::DATA_W-1:0] m_axis_tdata_o,
  output logic [resp_gen_cfg_pkg::KEEP_W-1:0] m_axis_tkeep_o,
  output logic                                m_axis_tvalid_o,
  output logic                                m_axis_tlast_o,
  input  logic                                m_axis_tready_i
);

  logic [47:0]                               src_mac;
  logic [31:0]                               src_ip;
  logic [resp_gen_cfg_pkg::NUM_QP-1:0][47:0] qp_mac;
  logic [resp_gen_cfg_pkg::NUM_QP-1:0][31:0] qp_ip;
  logic                                      cfg_en;
  logic                                      cap_valid;
  logic                                      cap_ready;
  logic                                      cap_is_ack;
  logic [23:0]                               cap_qp;
  logic [23:0]                               cap_psn;
  logic                                      hdr_valid;
  logic                                      hdr_ready;
  roce_hdr_pkg::roce_hdr_u                   hdr;
  logic                                      hdr_is_ack;

  qp_cfg_regs u_regs (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .src_mac_o    (src_mac),
    .src_ip_o     (src_ip),
    .qp_mac_o     (qp_mac),
    .qp_ip_o      (qp_ip),
    .cfg_en_o     (cfg_en)
  );

  rd_req_capture u_capture (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .cfg_en_i     (cfg_en),
    .req_valid_i  (req_valid_i),
    .req_data_i   (req_data_i),
    .req_ready_o  (req_ready_o),
    .cap_valid_o  (cap_valid),
    .cap_ready_i  (cap_ready),
    .cap_is_ack_o (cap_is_ack),
    .cap_qp_o     (cap_qp),
    .cap_psn_o    (cap_psn)
  );

  resp_hdr_build u_hdr (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .cap_valid_i  (cap_valid),
    .cap_ready_o  (cap_ready),
    .cap_is_ack_i (cap_is_ack),
    .cap_qp_i     (cap_qp),
    .cap_psn_i    (cap_psn),
    .src_mac_i    (src_mac),
    .src_ip_i     (src_ip),
    .qp_mac_i     (qp_mac),
    .qp_ip_i      (qp_ip),
    .hdr_valid_o  (hdr_valid),
    .hdr_ready_i  (hdr_ready),
    .hdr_o        (hdr),
    .hdr_is_ack_o (hdr_is_ack)
  );

  axis_beat_serializer u_ser (
    .core_clk        (core_clk),
    .core_aresetn    (core_aresetn),
    .hdr_valid_i     (hdr_valid),
    .hdr_ready_o     (hdr_ready),
    .hdr_i           (hdr),
    .hdr_is_ack_i    (hdr_is_ack),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tready_i (m_axis_tready_i)
  );

endmodule

// File: hw/axis_beat_serializer.sv
`timescale 1ns/10ps
module axis_beat_serializer (
  input  logic                                core_clk,
  input  logic                                core_aresetn,
  input  logic                                hdr_valid_i,
  output logic                                hdr_ready_o,
  input  roce_hdr_pkg::roce_hdr_u             hdr_i,
  input  logic                                hdr_is_ack_i,
  output logic [resp_gen_cfg_pkg::DATA_W-1:0] m_axis_tdata_o,
  output logic [resp_gen_cfg_pkg::KEEP_W-1:0] m_axis_tkeep_o,
  output logic                                m_axis_tvalid_o,
  output logic                                m_axis_tlast_o,
  input  logic                                m_axis_tready_i
);

  roce_hdr_pkg::roce_hdr_u                 hdr_q;
  logic [resp_gen_cfg_pkg::BEAT_CNT_W-1:0] beat_cnt;
  logic [resp_gen_cfg_pkg::LEN_W-1:0]      rem_q;  // bytes left incl. current beat
  logic [7:0]                              pay_byte;
  logic                                    last;
  logic                                    beat_fire;
  logic                                    hdr_fire;

  assign last      = rem_q <= resp_gen_cfg_pkg::LEN_W'(resp_gen_cfg_pkg::BEAT_BYTES);
  assign beat_fire = m_axis_tvalid_o && m_axis_tready_i;
  assign hdr_ready_o = !m_axis_tvalid_o || (beat_fire && last);
  assign hdr_fire  = hdr_valid_i && hdr_ready_o;
  assign pay_byte  = hdr_q.f.bth_psn[7:0];

  assign m_axis_tlast_o = m_axis_tvalid_o && last;
  assign m_axis_tkeep_o = last ? ~({resp_gen_cfg_pkg::KEEP_W{1'b1}} << rem_q) : '1;

  // payload fills every kept lane, the header then overwrites beat 0
  always_comb begin
    for (int i = 0; i < resp_gen_cfg_pkg::KEEP_W; i++) begin
      m_axis_tdata_o[i*8 +: 8] = m_axis_tkeep_o[i] ? pay_byte : 8'h00;
    end
    if (beat_cnt == '0) begin
      for (int i = 0; i < roce_hdr_pkg::HDR_BYTES; i++) begin
        m_axis_tdata_o[i*8 +: 8] = hdr_q.b[i];
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      m_axis_tvalid_o <= 1'b0;
      beat_cnt        <= '0;
      rem_q           <= '0;
    end else if (hdr_fire) begin
      m_axis_tvalid_o <= 1'b1;
      beat_cnt        <= '0;
      rem_q           <= hdr_is_ack_i ? resp_gen_cfg_pkg::LEN_W'(roce_hdr_pkg::HDR_BYTES)
                         : resp_gen_cfg_pkg::LEN_W'(roce_hdr_pkg::HDR_BYTES
                                                    + roce_hdr_pkg::RD_RESP_PAYLOAD_BYTES);
    end else if (beat_fire) begin
      m_axis_tvalid_o <= !last;
      beat_cnt        <= beat_cnt + 1'b1;
      rem_q           <= last ? '0 : rem_q - resp_gen_cfg_pkg::LEN_W'(resp_gen_cfg_pkg::BEAT_BYTES);
    end
  end

  always_ff @(posedge core_clk) begin
    if (hdr_fire) begin
      hdr_q <= hdr_i;
    end
  end

endmodule

// File: hw/resp_hdr_build.sv
`timescale 1ns/10ps
module resp_hdr_build (
  input  logic                                      core_clk,
  input  logic                                      core_aresetn,
  input  logic                                      cap_valid_i,
  output logic                                      cap_ready_o,
  input  logic                                      cap_is_ack_i,
  input  logic [23:0]                               cap_qp_i,
  input  logic [23:0]                               cap_psn_i,
  input  logic [47:0]                               src_mac_i,
  input  logic [31:0]                               src_ip_i,
  input  logic [resp_gen_cfg_pkg::NUM_QP-1:0][47:0] qp_mac_i,
  input  logic [resp_gen_cfg_pkg::NUM_QP-1:0][31:0] qp_ip_i,
  output logic                                      hdr_valid_o,
  input  logic                                      hdr_ready_i,
  output roce_hdr_pkg::roce_hdr_u                   hdr_o,
  output logic                                      hdr_is_ack_o
);

  logic [resp_gen_cfg_pkg::QP_IDX_W-1:0] qp_idx;
  logic [15:0]                           ip_len;
  roce_hdr_pkg::roce_hdr_t               f;
  logic [159:0]                          ip_words;
  logic [19:0]                           csum_acc;
  logic [16:0]                           csum_fold;
  logic [15:0]                           csum_sum;

  assign qp_idx = cap_qp_i[resp_gen_cfg_pkg::QP_IDX_W-1:0];
  // everything after the ethernet header, plus payload for a read response
  assign ip_len = 16'(roce_hdr_pkg::HDR_BYTES - roce_hdr_pkg::ETH_HDR_BYTES)
                  + (cap_is_ack_i ? 16'd0 : 16'(roce_hdr_pkg::RD_RESP_PAYLOAD_BYTES));

  always_comb begin
    f              = '0;  // checksums, reserved bits and AETH stay zero
    f.eth_dst      = qp_mac_i[qp_idx];
    f.eth_src      = src_mac_i;
    f.eth_type     = roce_hdr_pkg::ETH_TYPE_IPV4;
    f.ip_ver_ihl   = roce_hdr_pkg::IP_VER_IHL;
    f.ip_tos       = roce_hdr_pkg::IP_TOS;
    f.ip_total_len = ip_len;
    f.ip_id        = roce_hdr_pkg::IP_ID;
    f.ip_flags     = roce_hdr_pkg::IP_FLAGS;
    f.ip_ttl       = roce_hdr_pkg::IP_TTL;
    f.ip_proto     = roce_hdr_pkg::IP_PROTO_UDP;
    f.ip_src       = src_ip_i;
    f.ip_dst       = qp_ip_i[qp_idx];
    f.udp_src_port = roce_hdr_pkg::UDP_SRC_PORT;
    f.udp_dst_port = roce_hdr_pkg::UDP_DST_PORT;
    f.udp_len      = ip_len - 16'(roce_hdr_pkg::IP_HDR_BYTES);
    f.bth_opcode   = cap_is_ack_i ? roce_hdr_pkg::OPC_ACK : roce_hdr_pkg::OPC_RD_RESP_ONLY;
    f.bth_pkey     = roce_hdr_pkg::BTH_PKEY;
    f.bth_dest_qp  = cap_qp_i;
    f.bth_psn      = cap_psn_i;

    // ipv4 header as ten halfwords, checksum slot zero
    ip_words = {f.ip_ver_ihl, f.ip_tos, f.ip_total_len, f.ip_id, f.ip_flags,
                f.ip_ttl, f.ip_proto, 16'h0000, f.ip_src, f.ip_dst};
    csum_acc = '0;
    for (int i = 0; i < 10; i++) begin
      csum_acc = csum_acc + 20'(ip_words[i*16 +: 16]);
    end
    // two folds absorb any carry out of the first
    csum_fold   = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
    csum_sum    = csum_fold[15:0] + 16'(csum_fold[16]);
    f.ip_chksum = ~csum_sum;
  end

  assign cap_ready_o = !hdr_valid_o || hdr_ready_i;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      hdr_valid_o <= 1'b0;
    end else if (cap_ready_o) begin
      hdr_valid_o <= cap_valid_i;
    end
  end

  always_ff @(posedge core_clk) begin
    if (cap_valid_i && cap_ready_o) begin
      hdr_o.f      <= f;
      hdr_is_ack_o <= cap_is_ack_i;
    end
  end

endmodule

// File: hw/rd_req_capture.sv
`timescale 1ns/10ps
module rd_req_capture (
  input  logic                                core_clk,
  input  logic                                core_aresetn,
  input  logic                                cfg_en_i,
  input  logic                                req_valid_i,
  input  logic [resp_gen_cfg_pkg::DATA_W-1:0] req_data_i,
  output logic                                req_ready_o,
  output logic                                cap_valid_o,
  input  logic                                cap_ready_i,
  output logic                                cap_is_ack_o,
  output logic [23:0]                         cap_qp_o,
  output logic [23:0]                         cap_psn_o
);

  localparam int unsigned QP_BIT  = (roce_hdr_pkg::BTH_OFS + 5) * 8;
  localparam int unsigned PSN_BIT = (roce_hdr_pkg::BTH_OFS + 9) * 8;

  logic [7:0] opcode;
  logic       op_rd;
  logic       op_wr;
  logic       req_fire;

  assign opcode   = req_data_i[roce_hdr_pkg::BTH_OFS*8 +: 8];
  assign op_rd    = opcode == roce_hdr_pkg::OPC_RD_REQ;
  assign op_wr    = opcode == roce_hdr_pkg::OPC_WR_ONLY;

  // one slot, refilled in the same cycle it drains
  assign req_ready_o = cfg_en_i && (!cap_valid_o || cap_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      cap_valid_o <= 1'b0;
    end else if (req_fire) begin
      cap_valid_o <= op_rd | op_wr;  // other opcodes dropped here
    end else if (cap_ready_i) begin
      cap_valid_o <= 1'b0;
    end
  end

  // QP and PSN are big-endian on the wire
  always_ff @(posedge core_clk) begin
    if (req_fire) begin
      cap_is_ack_o <= op_wr;
      cap_qp_o     <= {req_data_i[QP_BIT +: 8],
                       req_data_i[QP_BIT + 8 +: 8],
                       req_data_i[QP_BIT + 16 +: 8]};
      cap_psn_o    <= {req_data_i[PSN_BIT +: 8],
                       req_data_i[PSN_BIT + 8 +: 8],
                       req_data_i[PSN_BIT + 16 +: 8]};
    end
  end

endmodule

// File: hw/qp_cfg_regs.sv
`timescale 1ns/10ps
module qp_cfg_regs (
  input  logic                                      core_clk,
  input  logic                                      core_aresetn,
  input  logic                                      psel_i,
  input  logic                                      penable_i,
  input  logic                                      pwrite_i,
  input  logic [7:0]                                paddr_i,
  input  logic [31:0]                               pwdata_i,
  output logic [31:0]                               prdata_o,
  output logic                                      pready_o,
  output logic                                      pslverr_o,
  output logic [47:0]                               src_mac_o,
  output logic [31:0]                               src_ip_o,
  output logic [resp_gen_cfg_pkg::NUM_QP-1:0][47:0] qp_mac_o,
  output logic [resp_gen_cfg_pkg::NUM_QP-1:0][31:0] qp_ip_o,
  output logic                                      cfg_en_o
);

  logic                                sel_src_lo;
  logic                                sel_src_hi;
  logic                                sel_src_ip;
  logic                                sel_ctrl;
  logic [resp_gen_cfg_pkg::NUM_QP-1:0] sel_qp_lo;
  logic [resp_gen_cfg_pkg::NUM_QP-1:0] sel_qp_hi;
  logic [resp_gen_cfg_pkg::NUM_QP-1:0] sel_qp_ip;
  logic                                hit;
  logic                                wr_en;

  always_comb begin
    sel_src_lo = paddr_i == resp_gen_cfg_pkg::REG_SRC_MAC_LO;
    sel_src_hi = paddr_i == resp_gen_cfg_pkg::REG_SRC_MAC_HI;
    sel_src_ip = paddr_i == resp_gen_cfg_pkg::REG_SRC_IP;
    sel_ctrl   = paddr_i == resp_gen_cfg_pkg::REG_CTRL;
    for (int q = 0; q < resp_gen_cfg_pkg::NUM_QP; q++) begin
      sel_qp_lo[q] = paddr_i == 8'(resp_gen_cfg_pkg::REG_QP_BASE
                     + q * resp_gen_cfg_pkg::REG_QP_STRIDE + resp_gen_cfg_pkg::QP_MAC_LO);
      sel_qp_hi[q] = paddr_i == 8'(resp_gen_cfg_pkg::REG_QP_BASE
                     + q * resp_gen_cfg_pkg::REG_QP_STRIDE + resp_gen_cfg_pkg::QP_MAC_HI);
      sel_qp_ip[q] = paddr_i == 8'(resp_gen_cfg_pkg::REG_QP_BASE
                     + q * resp_gen_cfg_pkg::REG_QP_STRIDE + resp_gen_cfg_pkg::QP_IP);
    end
    hit = sel_src_lo | sel_src_hi | sel_src_ip | sel_ctrl
          | (|sel_qp_lo) | (|sel_qp_hi) | (|sel_qp_ip);
  end

  // read mux, zero when nothing decodes
  always_comb begin
    prdata_o = '0;
    if (sel_src_lo) prdata_o = src_mac_o[31:0];
    if (sel_src_hi) prdata_o = {16'h0, src_mac_o[47:32]};
    if (sel_src_ip) prdata_o = src_ip_o;
    if (sel_ctrl)   prdata_o = {31'h0, cfg_en_o};
    for (int q = 0; q < resp_gen_cfg_pkg::NUM_QP; q++) begin
      if (sel_qp_lo[q]) prdata_o = qp_mac_o[q][31:0];
      if (sel_qp_hi[q]) prdata_o = {16'h0, qp_mac_o[q][47:32]};
      if (sel_qp_ip[q]) prdata_o = qp_ip_o[q];
    end
  end

  assign pready_o  = 1'b1;  // no wait states
  assign pslverr_o = psel_i & penable_i & ~hit;
  assign wr_en     = psel_i & penable_i & pwrite_i;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      src_mac_o <= '0;
      src_ip_o  <= '0;
      qp_mac_o  <= '0;
      qp_ip_o   <= '0;
      cfg_en_o  <= 1'b0;
    end else if (wr_en) begin
      if (sel_src_lo) src_mac_o[31:0]  <= pwdata_i;
      if (sel_src_hi) src_mac_o[47:32] <= pwdata_i[15:0];
      if (sel_src_ip) src_ip_o         <= pwdata_i;
      if (sel_ctrl)   cfg_en_o         <= pwdata_i[0];
      for (int q = 0; q < resp_gen_cfg_pkg::NUM_QP; q++) begin
        if (sel_qp_lo[q]) qp_mac_o[q][31:0]  <= pwdata_i;
        if (sel_qp_hi[q]) qp_mac_o[q][47:32] <= pwdata_i[15:0];
        if (sel_qp_ip[q]) qp_ip_o[q]         <= pwdata_i;
      end
    end
  end

endmodule

// File: hw/resp_gen_cfg_pkg.sv
package resp_gen_cfg_pkg;

  localparam int unsigned DATA_W     = 512;
  localparam int unsigned KEEP_W     = DATA_W / 8;
  localparam int unsigned BEAT_BYTES = 64;

  // enough for the 5 beats and 314 bytes of a read response
  localparam int unsigned BEAT_CNT_W = 3;
  localparam int unsigned LEN_W      = 9;

  localparam int unsigned NUM_QP   = 4;
  localparam int unsigned QP_IDX_W = 2;

  // APB byte addresses
  localparam logic [7:0] REG_SRC_MAC_LO = 8'h00;
  localparam logic [7:0] REG_SRC_MAC_HI = 8'h04;
  localparam logic [7:0] REG_SRC_IP     = 8'h08;
  localparam logic [7:0] REG_CTRL       = 8'h0C;
  localparam logic [7:0] REG_QP_BASE    = 8'h10;
  localparam logic [7:0] REG_QP_STRIDE  = 8'h10;

  // offsets inside one qp block
  localparam logic [7:0] QP_MAC_LO = 8'h0;
  localparam logic [7:0] QP_MAC_HI = 8'h4;
  localparam logic [7:0] QP_IP     = 8'h8;

endpackage

// File: hw/roce_hdr_pkg.sv
package roce_hdr_pkg;

  localparam int unsigned HDR_BYTES             = 58;
  localparam int unsigned RD_RESP_PAYLOAD_BYTES = 256;

  // header section sizes, BTH starts right after UDP
  localparam int unsigned ETH_HDR_BYTES = 14;
  localparam int unsigned IP_HDR_BYTES  = 20;
  localparam int unsigned UDP_HDR_BYTES = 8;
  localparam int unsigned BTH_OFS       = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

  localparam logic [7:0] OPC_WR_ONLY      = 8'h0A;
  localparam logic [7:0] OPC_RD_REQ       = 8'h0C;
  localparam logic [7:0] OPC_RD_RESP_ONLY = 8'h10;
  localparam logic [7:0] OPC_ACK          = 8'h11;

  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL    = 8'h45;
  localparam logic [7:0]  IP_TOS        = 8'hb8;
  localparam logic [15:0] IP_ID         = 16'h5555;
  localparam logic [15:0] IP_FLAGS      = 16'h4000;  // don't fragment
  localparam logic [7:0]  IP_TTL        = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
  localparam logic [15:0] UDP_SRC_PORT  = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT  = 16'h12b7;  // RoCEv2
  localparam logic [15:0] BTH_PKEY      = 16'h666f;

  // wire order, first field is byte 0 on the wire
  typedef struct packed {
    logic [47:0] eth_dst;
    logic [47:0] eth_src;
    logic [15:0] eth_type;
    logic [7:0]  ip_ver_ihl;
    logic [7:0]  ip_tos;
    logic [15:0] ip_total_len;
    logic [15:0] ip_id;
    logic [15:0] ip_flags;
    logic [7:0]  ip_ttl;
    logic [7:0]  ip_proto;
    logic [15:0] ip_chksum;
    logic [31:0] ip_src;
    logic [31:0] ip_dst;
    logic [15:0] udp_src_port;
    logic [15:0] udp_dst_port;
    logic [15:0] udp_len;
    logic [15:0] udp_chksum;
    logic [7:0]  bth_opcode;
    logic [7:0]  bth_flags;
    logic [15:0] bth_pkey;
    logic [7:0]  bth_rsvd;
    logic [23:0] bth_dest_qp;
    logic [7:0]  bth_ack_req;
    logic [23:0] bth_psn;
    logic [31:0] aeth;
  } roce_hdr_t;

  // b[0] overlays the top of f, i.e. wire byte 0
  typedef union packed {
    roce_hdr_t                 f;
    logic [0:HDR_BYTES-1][7:0] b;
  } roce_hdr_u;

endpackage
